/* tb.f */
design/snoop_pkg.sv
design/snoop_wr_if.sv
design/axis_snooper.sv
design/packet_buffer.sv
design/byte_sum_core.sv
design/snoop_top.sv
verif/tb_snoop_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the snooper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_snoop_top -o tb_snoop_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_snoop_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

/* verif/tb_snoop_top.sv */
`default_nettype none

module tb_snoop_top;
    import snoop_pkg::*;

    // Cycle budgets of the wait loops
    localparam int RESULT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 400;

    logic clk;
    logic rst;
    data_t s_tdata;
    keep_t s_tkeep;
    logic s_tvalid;
    logic s_tready;
    logic s_tlast;
    logic result_valid;
    sum_t result_sum;
    bytes_t result_bytes;
    logic result_trunc;
    cnt_t drop_count;

    // Rising edges since time zero
    int cyc = 0;

    // Model results, one entry per packet in sending order
    sum_t exp_sum [$];
    bytes_t exp_bytes [$];
    logic exp_trunc [$];
    int exp_due [$];

    // Next entry a result may match
    int match_pos;
    int results;
    int sent;
    bit dense_mode;
    string test_name;

    snoop_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .s_tdata_i      (s_tdata),
        .s_tkeep_i      (s_tkeep),
        .s_tvalid_i     (s_tvalid),
        .s_tready_i     (s_tready),
        .s_tlast_i      (s_tlast),
        .result_valid_o (result_valid),
        .result_sum_o   (result_sum),
        .result_bytes_o (result_bytes),
        .result_trunc_o (result_trunc),
        .drop_count_o   (drop_count)
    );

    // 20 unit clock period
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic value_fail(input string what, input int expected, input int actual);
        $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                 test_name, what, expected, actual);
        abort_run();
    endtask

    task automatic plain_fail(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        abort_run();
    endtask

    // Inputs change 1 unit after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Link idle, ready and data still wander
    task automatic idle_cycles(input int n);
        repeat (n) begin
            s_tvalid = 1'b0;
            s_tlast = 1'b0;
            s_tready = ($urandom_range(1, 0) == 1);
            s_tdata = {$urandom(), $urandom()};
            s_tkeep = keep_t'($urandom_range(255, 0));
            next_cycle();
        end
    endtask

    // Sends one packet of n beats and queues its expected result
    task automatic send_packet(input int n, input bit rand_keep);
        int b;
        int stalls;
        int stored;
        sum_t sum;
        bytes_t nbytes;
        keep_t keep;
        b = 0;
        sum = '0;
        nbytes = '0;
        while (b < n) begin
            if ($urandom_range(3, 0) == 0) begin
                // TVALID gap inside the packet
                idle_cycles(1);
            end else begin
                if (rand_keep) begin
                    keep = keep_t'($urandom_range(255, 0));
                end else if (b == n - 1) begin
                    keep = keep_t'($urandom_range(255, 1));
                end else begin
                    keep = '1;
                end
                s_tdata = {$urandom(), $urandom()};
                s_tkeep = keep;
                s_tvalid = 1'b1;
                s_tlast = (b == n - 1);
                // Beat held while the sink stalls it
                stalls = ($urandom_range(3, 0) == 0) ? int'($urandom_range(3, 1)) : 0;
                s_tready = 1'b0;
                repeat (stalls) begin
                    next_cycle();
                end
                s_tready = 1'b1;
                // Only the first DEPTH beats end up in the buffer
                if (b < DEPTH) begin
                    for (int i = 0; i < KEEP_W; i++) begin
                        if (keep[i]) begin
                            sum = sum + sum_t'(s_tdata[8*i +: 8]);
                            nbytes = nbytes + bytes_t'(1);
                        end
                    end
                end
                if (b == n - 1) begin
                    stored = (n > DEPTH) ? DEPTH : n;
                    exp_sum.push_back(sum);
                    exp_bytes.push_back(nbytes);
                    exp_trunc.push_back(n > DEPTH);
                    // Accepted at the coming edge, result stored+5 cycles later
                    exp_due.push_back(cyc + stored + 5);
                end
                b++;
                next_cycle();
            end
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        sent++;
    endtask

    // Idles the link until every sent packet has reported
    task automatic wait_for_results();
        int t;
        t = 0;
        while (results < sent && t < RESULT_TIMEOUT) begin
            idle_cycles(1);
            t++;
        end
        if (results < sent) begin
            plain_fail("no result arrived for the last packet in time");
        end
    endtask

    function automatic bit entry_matches(input int j);
        return result_sum == exp_sum[j] && result_bytes == exp_bytes[j]
            && result_trunc == exp_trunc[j] && cyc == exp_due[j];
    endfunction

    task automatic check_result();
        int j;
        if (match_pos >= exp_sum.size()) begin
            plain_fail("a result was reported with no packet outstanding");
        end
        if (dense_mode) begin
            // Entries passed over were dropped by the snooper
            j = match_pos;
            while (j < exp_sum.size() && !entry_matches(j)) begin
                j++;
            end
            if (j < exp_sum.size()) begin
                match_pos = j;
            end
        end else begin
            assert (drop_count == '0)
                else value_fail("drop count", 0, int'(drop_count));
        end
        assert (result_sum == exp_sum[match_pos])
            else value_fail("byte sum", int'(exp_sum[match_pos]), int'(result_sum));
        assert (result_bytes == exp_bytes[match_pos])
            else value_fail("byte count", int'(exp_bytes[match_pos]), int'(result_bytes));
        assert (result_trunc == exp_trunc[match_pos])
            else value_fail("trunc flag", int'(exp_trunc[match_pos]), int'(result_trunc));
        assert (cyc == exp_due[match_pos])
            else value_fail("result cycle", exp_due[match_pos], cyc);
        match_pos++;
        results++;
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (result_valid) begin
            check_result();
        end
    end

    initial begin
        void'($urandom(32'ha02e73da));
        clk = 1'b0;
        rst = 1'b1;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tready = 1'b0;
        s_tlast = 1'b0;
        match_pos = 0;
        results = 0;
        sent = 0;
        dense_mode = 1'b0;
        test_name = "reset";

        repeat (16) begin
            next_cycle();
        end
        rst = 1'b0;

        // Nothing reported and nothing dropped on an idle link
        for (int c = 0; c < 20; c++) begin
            idle_cycles(1);
            assert (!result_valid)
                else value_fail("result valid", 0, int'(result_valid));
            assert (drop_count == '0)
                else value_fail("drop count", 0, int'(drop_count));
        end

        // Spaced packets, all fit the buffer
        test_name = "spaced";
        for (int p = 0; p < 30; p++) begin
            send_packet(int'($urandom_range(64, 1)), 1'b0);
            wait_for_results();
            idle_cycles(80 + int'($urandom_range(20, 0)));
        end

        // Longer than the buffer
        test_name = "truncation";
        for (int p = 0; p < 6; p++) begin
            send_packet(int'($urandom_range(70, 65)), 1'b0);
            wait_for_results();
            idle_cycles(80 + int'($urandom_range(20, 0)));
        end

        // Back to back with random TKEEP, some packets get dropped
        test_name = "dense";
        dense_mode = 1'b1;
        for (int p = 0; p < 40; p++) begin
            send_packet(int'($urandom_range(70, 1)), 1'b1);
        end
        for (int t = 0; t < DRAIN_TIMEOUT && results + int'(drop_count) < sent; t++) begin
            idle_cycles(1);
        end
        if (results + int'(drop_count) < sent) begin
            plain_fail("packets still unaccounted for after the link went idle");
        end
        idle_cycles(100);
        assert (results + int'(drop_count) == sent)
            else value_fail("results plus drops", sent, results + int'(drop_count));

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/snoop_top.sv */
`default_nettype none

module snoop_top (
    input  logic              clk,
    input  logic              rst,
    input  snoop_pkg::data_t  s_tdata_i,
    input  snoop_pkg::keep_t  s_tkeep_i,
    input  logic              s_tvalid_i,
    input  logic              s_tready_i,
    input  logic              s_tlast_i,
    output logic              result_valid_o,
    output snoop_pkg::sum_t   result_sum_o,
    output snoop_pkg::bytes_t result_bytes_o,
    output logic              result_trunc_o,
    output snoop_pkg::cnt_t   drop_count_o
);
    import snoop_pkg::*;

    // Snooper to buffer write path
    snoop_wr_if wr_bus ();

    // Core handshake and statistics
    logic core_rdy;
    logic drop_pulse;

    // Buffer totals handed to the core
    logic pkt_done;
    beats_t pkt_beats;
    bytes_t pkt_bytes;
    logic pkt_trunc;

    // Core read-back port
    addr_t rd_addr;
    data_t rd_data;

    axis_snooper i_snooper (
        .clk        (clk),
        .rst        (rst),
        .tdata_i    (s_tdata_i),
        .tkeep_i    (s_tkeep_i),
        .tvalid_i   (s_tvalid_i),
        .tready_i   (s_tready_i),
        .tlast_i    (s_tlast_i),
        .core_rdy_i (core_rdy),
        .wr         (wr_bus.snooper),
        .drop_o     (drop_pulse)
    );

    packet_buffer i_buffer (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr_bus.buffer),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data),
        .pkt_done_o  (pkt_done),
        .pkt_beats_o (pkt_beats),
        .pkt_bytes_o (pkt_bytes),
        .pkt_trunc_o (pkt_trunc)
    );

    byte_sum_core i_core (
        .clk            (clk),
        .rst            (rst),
        .pkt_done_i     (pkt_done),
        .pkt_beats_i    (pkt_beats),
        .pkt_bytes_i    (pkt_bytes),
        .pkt_trunc_i    (pkt_trunc),
        .rd_addr_o      (rd_addr),
        .rd_data_i      (rd_data),
        .core_rdy_o     (core_rdy),
        .drop_i         (drop_pulse),
        .result_valid_o (result_valid_o),
        .result_sum_o   (result_sum_o),
        .result_bytes_o (result_bytes_o),
        .result_trunc_o (result_trunc_o),
        .drop_count_o   (drop_count_o)
    );

endmodule

`default_nettype wire

/* design/byte_sum_core.sv */
`default_nettype none

module byte_sum_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              pkt_done_i,
    input  snoop_pkg::beats_t pkt_beats_i,
    input  snoop_pkg::bytes_t pkt_bytes_i,
    input  logic              pkt_trunc_i,
    output snoop_pkg::addr_t  rd_addr_o,
    input  snoop_pkg::data_t  rd_data_i,
    output logic              core_rdy_o,
    input  logic              drop_i,
    output logic              result_valid_o,
    output snoop_pkg::sum_t   result_sum_o,
    output snoop_pkg::bytes_t result_bytes_o,
    output logic              result_trunc_o,
    output snoop_pkg::cnt_t   drop_count_o
);
    import snoop_pkg::*;

    // Read-back sequencer states
    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_READ,
        CORE_FINISH
    } core_state_e;

    core_state_e state_q;

    // Next beat to read, reaches pkt_beats_i when all are issued
    beats_t rd_cnt_q;

    // Read data of the previous cycle is valid
    logic rd_vld_q;
    logic issue;

    sum_t sum_q;
    sum_t word_sum;

    // Buffer totals stay stable until we raise ready again
    assign issue = (state_q == CORE_READ) && (rd_cnt_q != pkt_beats_i);
    assign rd_addr_o = rd_cnt_q[ADDR_W-1:0];

    // Ready is just the idle level
    assign core_rdy_o = (state_q == CORE_IDLE);

    // Add the eight bytes of the returning word
    always_comb begin
        word_sum = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            word_sum = word_sum + sum_t'(rd_data_i[8*i +: 8]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= CORE_IDLE;
            rd_cnt_q <= '0;
            rd_vld_q <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            rd_vld_q <= issue;
            result_valid_o <= 1'b0;
            case (state_q)
                CORE_IDLE: begin
                    if (pkt_done_i) begin
                        state_q <= CORE_READ;
                        rd_cnt_q <= '0;
                    end
                end
                CORE_READ: begin
                    // One read per cycle until every stored beat is issued
                    if (issue) begin
                        rd_cnt_q <= rd_cnt_q + beats_t'(1);
                    end else begin
                        state_q <= CORE_FINISH;
                    end
                end
                CORE_FINISH: begin
                    // Last word was added on the way in here
                    state_q <= CORE_IDLE;
                    result_valid_o <= 1'b1;
                end
                default: begin
                    state_q <= CORE_IDLE;
                end
            endcase
        end
    end

    // Sum restarts whenever the core sits idle
    always_ff @(posedge clk) begin
        if (state_q == CORE_IDLE) begin
            sum_q <= '0;
        end else if (rd_vld_q) begin
            sum_q <= sum_q + word_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CORE_FINISH) begin
            result_sum_o <= sum_q;
            result_bytes_o <= pkt_bytes_i;
            result_trunc_o <= pkt_trunc_i;
        end
    end

    // Dropped packet counter, sticks at all ones
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count_o <= '0;
        end else if (drop_i && (drop_count_o != '1)) begin
            drop_count_o <= drop_count_o + cnt_t'(1);
        end
    end

endmodule

`default_nettype wire

/* design/packet_buffer.sv */
`default_nettype none

module packet_buffer (
    input  logic               clk,
    input  logic               rst,
    snoop_wr_if.buffer         wr,
    input  snoop_pkg::addr_t   rd_addr_i,
    output snoop_pkg::data_t   rd_data_o,
    output logic               pkt_done_o,
    output snoop_pkg::beats_t  pkt_beats_o,
    output snoop_pkg::bytes_t  pkt_bytes_o,
    output logic               pkt_trunc_o
);
    import snoop_pkg::*;

    // Packet storage, one stream word per entry
    data_t mem [DEPTH];

    // Running totals of the packet being written
    beats_t beat_cnt_q;
    bytes_t byte_cnt_q;

    // Totals including the beat on the bus this cycle
    beats_t beat_total;
    bytes_t byte_total;

    // Single write port, registered read port
    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data_o <= mem[rd_addr_i];
    end

    // Discarded beats add neither a beat nor their bytes
    assign beat_total = wr.wr_en ? beat_cnt_q + beats_t'(1) : beat_cnt_q;
    assign byte_total = wr.wr_en ? byte_cnt_q + bytes_t'(wr.byte_inc) : byte_cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q <= '0;
            byte_cnt_q <= '0;
            pkt_done_o <= 1'b0;
        end else begin
            pkt_done_o <= wr.done;
            if (wr.done) begin
                beat_cnt_q <= '0;
                byte_cnt_q <= '0;
            end else begin
                beat_cnt_q <= beat_total;
                byte_cnt_q <= byte_total;
            end
        end
    end

    // Totals held for the core until the next packet ends
    always_ff @(posedge clk) begin
        if (wr.done) begin
            pkt_beats_o <= beat_total;
            pkt_bytes_o <= byte_total;
            // Last beat came without a write, so the buffer had filled up
            pkt_trunc_o <= !wr.wr_en;
        end
    end

endmodule

`default_nettype wire

/* design/axis_snooper.sv */
`default_nettype none

module axis_snooper (
    input  logic             clk,
    input  logic             rst,
    input  snoop_pkg::data_t tdata_i,
    input  snoop_pkg::keep_t tkeep_i,
    input  logic             tvalid_i,
    input  logic             tready_i,
    input  logic             tlast_i,
    input  logic             core_rdy_i,
    snoop_wr_if.snooper      wr,
    output logic             drop_o
);
    import snoop_pkg::*;

    // Registered copy of the snooped stream
    data_t tdata_q;
    keep_t tkeep_q;
    logic tvalid_q;
    logic tready_q;
    logic tlast_q;

    snoop_state_e state_q;

    // Tracks whether the link is between first and last beat
    logic in_packet_q;

    // Set once ready has been seen low after our last done
    logic rdy_fresh_q;

    // Buffer full so further beats of this packet are discarded
    logic full_q;
    addr_t addr_q;

    logic beat_acc;
    logic pkt_mid;
    logic capture_beat;
    logic write_beat;
    logic done_beat;
    data_t masked_data;
    inc_t keep_cnt;

    // Input register stage
    always_ff @(posedge clk) begin
        if (rst) begin
            tvalid_q <= 1'b0;
        end else begin
            tvalid_q <= tvalid_i;
        end
    end

    always_ff @(posedge clk) begin
        tdata_q <= tdata_i;
        tkeep_q <= tkeep_i;
        tready_q <= tready_i;
        tlast_q <= tlast_i;
    end

    // Beat counts only when both sides agreed on the link
    assign beat_acc = tvalid_q && tready_q;

    // Mid-packet as seen from the next beat onwards
    assign pkt_mid = beat_acc ? !tlast_q : in_packet_q;

    // Zero the bytes TKEEP marks invalid and count the kept ones
    always_comb begin
        masked_data = '0;
        keep_cnt = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            if (tkeep_q[i]) begin
                masked_data[8*i +: 8] = tdata_q[8*i +: 8];
                keep_cnt = keep_cnt + inc_t'(1);
            end
        end
    end

    assign capture_beat = (state_q == CAPTURE) && beat_acc;
    // Beats past DEPTH are dropped on the floor
    assign write_beat = capture_beat && !full_q;
    assign done_beat = capture_beat && tlast_q;

    assign wr.wr_en = write_beat;
    assign wr.addr = addr_q;
    assign wr.data = masked_data;
    assign wr.byte_inc = keep_cnt;
    assign wr.done = done_beat;

    // A packet ending outside CAPTURE was never stored
    assign drop_o = (state_q != CAPTURE) && beat_acc && tlast_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            in_packet_q <= 1'b0;
            rdy_fresh_q <= 1'b1;
            full_q <= 1'b0;
            addr_q <= '0;
        end else begin
            if (beat_acc) begin
                in_packet_q <= !tlast_q;
            end
            // Core has taken the last packet so its next ready is genuine
            if (!core_rdy_i) begin
                rdy_fresh_q <= 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (core_rdy_i && rdy_fresh_q) begin
                        state_q <= pkt_mid ? ALIGN : CAPTURE;
                    end
                end
                ALIGN: begin
                    // Skip the rest of the packet already in flight
                    if (beat_acc && tlast_q) begin
                        state_q <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (write_beat) begin
                        addr_q <= addr_q + addr_t'(1);
                        if (addr_q == addr_t'(DEPTH - 1)) begin
                            full_q <= 1'b1;
                        end
                    end
                    if (done_beat) begin
                        state_q <= IDLE;
                        addr_q <= '0;
                        full_q <= 1'b0;
                        // Ready stays high a while after done
                        rdy_fresh_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/snoop_wr_if.sv */
`default_nettype none

// Write path from the snooper into the packet buffer
interface snoop_wr_if;
    import snoop_pkg::*;

    // One-cycle strobe per stored beat
    logic wr_en;

    // Word address inside the buffer
    addr_t addr;

    // Beat with invalid bytes already zeroed
    data_t data;

    // Number of kept bytes in this beat
    inc_t byte_inc;

    // Last captured beat, with or without a write
    logic done;

    // Snooper side drives everything
    modport snooper (output wr_en, addr, data, byte_inc, done);

    // Buffer side only listens
    modport buffer (input wr_en, addr, data, byte_inc, done);

endinterface

`default_nettype wire

/* design/snoop_pkg.sv */
`default_nettype none

package snoop_pkg;

    // Stream word and byte-enable widths
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // Buffer geometry, 64 words of 64 bits
    localparam int ADDR_W = 6;
    localparam int DEPTH = 64;

    // Up to 512 bytes per stored packet
    localparam int BYTES_W = 10;

    // Result and statistics widths
    localparam int SUM_W = 16;
    localparam int CNT_W = 16;

    // One stream word and its byte enables
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;

    // Buffer word address
    typedef logic [ADDR_W-1:0] addr_t;

    // Stored beat count, needs one more bit to reach DEPTH
    typedef logic [ADDR_W:0] beats_t;

    typedef logic [BYTES_W-1:0] bytes_t;

    // Valid bytes in one beat, 0 to 8
    typedef logic [3:0] inc_t;

    // Byte sum wraps modulo 2^16
    typedef logic [SUM_W-1:0] sum_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // Snooper packet alignment states
    typedef enum logic [1:0] {
        IDLE,
        ALIGN,
        CAPTURE
    } snoop_state_e;

endpackage

`default_nettype wire
